// ==== tb.f ====
+incdir+common
common/dcache_pkg.sv
source/sync_ram.sv
dcache/dcache_way.sv
dcache/dcache_datapath.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
verif/dcache_tb.sv

// ==== verif/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_TESTS   = 5;
    localparam int IMG_LINES = 1024;    // tags 0..7 over all 128 sets

    logic    clk_g, arst_n;
    logic    valid, op;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata, rdata;
    logic    addr_ok, data_ok;
    logic    rd_req, rd_finish, wr_req, wr_finish;
    addr_t   rd_addr, wr_addr;
    line_t   rd_data, wr_data;

    line_t   mem_img [IMG_LINES];   // memory contents
    line_t   ref_img [IMG_LINES];   // what the cpu should read back
    integer  seed = 45851;
    int      rd_count, wr_count;
    int      bus_seq, rd_seq, wr_seq;   // order of bus requests
    addr_t   last_rd_addr, last_wr_addr;
    line_t   last_wr_data;

    dcache_top i_dut (.*);

    initial begin
        clk_g = 1'b0;
        forever #5 clk_g = ~clk_g;
    end

    //////////////////////////////
    // helpers

    function automatic int slot_of(input tag_t t, input index_t ix);
        return {t[2:0], ix};
    endfunction

    function automatic line_t image_line(input int slot);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w] = ((slot * 8 + w) * 32'h9E37_79B1) ^ 32'h0F1E_2D3C;  // unique per word address
        end
        return l;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) stop_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                            $time, what, got, exp));
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) stop_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                            $time, what, got, exp));
    endtask

    task automatic check_line(input string what, input line_t got, input line_t exp);
        if (got !== exp) stop_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                            $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                            $time, what, got, exp));
    endtask

    // byte merge of a store into the reference image
    task automatic merge_store(input int slot, input offset_t off, input strb_t ws,
                               input word_t wd);
        for (int b = 0; b < 4; b++) begin
            if (ws[b]) ref_img[slot][off[4:2]][8*b +: 8] = wd[8*b +: 8];
        end
    endtask

    // one request, lat counts negedges from acceptance to data_ok
    task automatic access(input logic st, input tag_t t, input index_t ix, input offset_t off,
                          input strb_t ws, input word_t wd, output word_t got, output int lat);
        @(posedge clk_g);
        #1;
        valid  = 1'b1;
        op     = st;
        tag    = t;
        index  = ix;
        offset = off;
        wstrb  = ws;
        wdata  = wd;
        @(negedge clk_g);
        while (!addr_ok) @(negedge clk_g);
        @(posedge clk_g);       // taken here
        #1;
        valid = 1'b0;
        lat   = 1;
        @(negedge clk_g);
        while (!data_ok) begin
            @(negedge clk_g);
            lat++;
        end
        got = rdata;
    endtask

    task automatic load_check(input tag_t t, input index_t ix, input offset_t off,
                              output int lat);
        word_t got;
        access(1'b0, t, ix, off, '0, '0, got, lat);
        check_word("rdata", got, ref_img[slot_of(t, ix)][off[4:2]]);
    endtask

    task automatic store_check(input tag_t t, input index_t ix, input offset_t off,
                               input strb_t ws, input word_t wd, output int lat);
        word_t got;
        merge_store(slot_of(t, ix), off, ws, wd);
        access(1'b1, t, ix, off, ws, wd, got, lat);
        check_word("rdata after store", got, ref_img[slot_of(t, ix)][off[4:2]]);  // merged word
    endtask

    //////////////////////////////
    // memory model, line reads and writebacks with random delay

    initial begin : memory_model
        int slot;
        int dly;
        rd_finish = 1'b0;
        wr_finish = 1'b0;
        rd_data   = '0;
        for (int s = 0; s < IMG_LINES; s++) begin
            mem_img[s] = image_line(s);
            ref_img[s] = mem_img[s];
        end
        forever begin
            @(negedge clk_g);
            dly = 1 + ({$random(seed)} % 4);   // 1 to 4 cycles
            if (wr_req) begin
                if (wr_addr.tag > 7) stop_run("memory model got a writeback outside its image");
                slot          = slot_of(wr_addr.tag, wr_addr.index);
                bus_seq++;
                wr_seq        = bus_seq;
                wr_count++;
                last_wr_addr  = wr_addr;
                last_wr_data  = wr_data;
                mem_img[slot] = wr_data;
                repeat (dly) @(posedge clk_g);
                #1;
                wr_finish = 1'b1;
                @(posedge clk_g);
                #1;
                wr_finish = 1'b0;
            end else if (rd_req) begin
                if (rd_addr.tag > 7) stop_run("memory model got a read outside its image");
                slot         = slot_of(rd_addr.tag, rd_addr.index);
                bus_seq++;
                rd_seq       = bus_seq;
                rd_count++;
                last_rd_addr = rd_addr;
                repeat (dly) @(posedge clk_g);
                #1;
                rd_data   = mem_img[slot];
                rd_finish = 1'b1;
                @(posedge clk_g);
                #1;
                rd_finish = 1'b0;
            end
        end
    end

    //////////////////////////////
    // directed tests

    task automatic test_reset_and_first_load();
        int lat;
        int rd_b;
        @(negedge clk_g);
        check_flag("addr_ok", addr_ok, 1'b1);
        check_flag("rd_req", rd_req, 1'b0);
        check_flag("wr_req", wr_req, 1'b0);
        check_flag("data_ok", data_ok, 1'b0);
        rd_b = rd_count;
        load_check(20'h1, 7'h05, 5'h0C, lat);      // cold miss
        check_flag("rd_req on first load", rd_count == rd_b + 1, 1'b1);
        check_addr("rd_addr", last_rd_addr, {20'h1, 7'h05, 5'h00});
    endtask

    task automatic test_load_hit();
        int lat;
        int rd_b;
        rd_b = rd_count;
        load_check(20'h1, 7'h05, 5'h1C, lat);      // same line, other word
        check_flag("rd_req on load hit", rd_count != rd_b, 1'b0);
        check_flag("data_ok two cycles after accept", lat == 2, 1'b1);
    endtask

    task automatic test_store_hit();
        int lat;
        int rd_b;
        int wr_b;
        rd_b = rd_count;
        wr_b = wr_count;
        store_check(20'h1, 7'h05, 5'h0C, 4'b0110, 32'hDEAD_BEEF, lat);  // middle bytes only
        check_flag("store hit latency", lat == 2, 1'b1);
        load_check(20'h1, 7'h05, 5'h0C, lat);
        check_flag("rd_req on store hit", rd_count != rd_b, 1'b0);
        check_flag("wr_req on store hit", wr_count != wr_b, 1'b0);
    endtask

    task automatic test_lru_eviction();
        int lat;
        int rd_b;
        int wr_b;
        index_t ix;
        ix = 7'h15;
        load_check(20'h1, ix, 5'h04, lat);          // a into way0
        wr_b = wr_count;
        load_check(20'h2, ix, 5'h08, lat);          // b into the free way
        check_flag("wr_req filling the free way", wr_count != wr_b, 1'b0);
        store_check(20'h1, ix, 5'h10, 4'b1111, 32'h1234_5678, lat);  // a now dirty
        load_check(20'h2, ix, 5'h08, lat);          // b most recent, a is lru
        wr_b = wr_count;
        load_check(20'h3, ix, 5'h00, lat);          // evicts dirty a
        check_flag("writeback of dirty victim", wr_count == wr_b + 1, 1'b1);
        check_flag("wr_req before rd_req", wr_seq < rd_seq, 1'b1);
        check_addr("wr_addr", last_wr_addr, {20'h1, ix, 5'h00});
        check_line("wr_data", last_wr_data, ref_img[slot_of(20'h1, ix)]);
        wr_b = wr_count;
        load_check(20'h4, ix, 5'h14, lat);          // evicts clean b
        check_flag("wr_req on clean victim", wr_count != wr_b, 1'b0);
        rd_b = rd_count;
        load_check(20'h3, ix, 5'h00, lat);          // c kept
        check_flag("rd_req on kept line", rd_count != rd_b, 1'b0);
    endtask

    task automatic test_store_miss();
        int lat;
        int rd_b;
        int wr_b;
        index_t ix;
        ix   = 7'h2A;
        rd_b = rd_count;
        wr_b = wr_count;
        store_check(20'h5, ix, 5'h18, 4'b1001, 32'hA1B2_C3D4, lat);  // refill then merge
        check_flag("rd_req on store miss", rd_count == rd_b + 1, 1'b1);
        check_flag("wr_req on store miss", wr_count != wr_b, 1'b0);
        load_check(20'h6, ix, 5'h00, lat);          // free way
        wr_b = wr_count;
        load_check(20'h7, ix, 5'h00, lat);          // pushes out the merged line
        check_flag("writeback of merged line", wr_count == wr_b + 1, 1'b1);
        check_addr("wr_addr", last_wr_addr, {20'h5, ix, 5'h00});
        check_line("wr_data", last_wr_data, ref_img[slot_of(20'h5, ix)]);
        rd_b = rd_count;
        load_check(20'h5, ix, 5'h18, lat);          // back from memory
        check_flag("rd_req on reload", rd_count == rd_b + 1, 1'b1);
    endtask

    //////////////////////////////
    // run

    initial begin : watchdog
        repeat (N_TESTS * 200) @(posedge clk_g);
        stop_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin : main
        valid  = 1'b0;
        op     = 1'b0;
        tag    = '0;
        index  = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        arst_n = 1'b1;
        #1;
        arst_n = 1'b0;      // falling edge starts the async reset
        repeat (8) @(posedge clk_g);
        #1;
        arst_n = 1'b1;
        test_reset_and_first_load();
        test_load_hit();
        test_store_hit();
        test_lru_eviction();
        test_store_miss();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== dcache/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top (
    input  logic                clk_g,
    input  logic                arst_n,
    // processor side
    input  logic                valid,
    input  logic                op,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::strb_t   wstrb,
    input  dcache_pkg::word_t   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    // memory read
    output logic                rd_req,
    output dcache_pkg::addr_t   rd_addr,
    input  logic                rd_finish,
    input  dcache_pkg::line_t   rd_data,
    // memory write, whole line
    output logic                wr_req,
    output dcache_pkg::addr_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_finish
);
    import dcache_pkg::*;

    logic    hit0, hit1, dirty0, dirty1;
    tag_t    tag0, tag1, wr_tag;
    line_t   line0, line1, wr_line;
    index_t  rd_index, wr_index;
    logic    we0, we1, set_dirty;
    logic    way_sel, fill, capture, req_store;
    offset_t req_offset;
    strb_t   req_wstrb;
    word_t   req_wdata;

    dcache_ctrl i_ctrl (.*);    // names line up one to one

    dcache_datapath i_datapath (
        .clk_g, .arst_n, .line0, .line1, .way_sel, .fill, .capture,
        .req_store, .req_offset, .req_wstrb, .req_wdata,
        .refill_line (rd_data),
        .wr_line, .victim_line (wr_data), .rdata
    );

    dcache_way way0 (
        .clk_g, .arst_n, .rd_index, .lookup_tag (wr_tag), .we (we0),
        .wr_index, .wr_tag, .wr_line, .set_dirty,
        .hit (hit0), .line (line0), .tag (tag0), .victim_dirty (dirty0)
    );

    dcache_way way1 (
        .clk_g, .arst_n, .rd_index, .lookup_tag (wr_tag), .we (we1),
        .wr_index, .wr_tag, .wr_line, .set_dirty,
        .hit (hit1), .line (line1), .tag (tag1), .victim_dirty (dirty1)
    );

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                clk_g,
    input  logic                arst_n,
    // processor request
    input  logic                valid,
    input  logic                op,          // 1 = store
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::strb_t   wstrb,
    input  dcache_pkg::word_t   wdata,
    // way status
    input  logic                hit0,
    input  logic                hit1,
    input  logic                dirty0,
    input  logic                dirty1,
    input  dcache_pkg::tag_t    tag0,
    input  dcache_pkg::tag_t    tag1,
    // memory finish pulses
    input  logic                rd_finish,
    input  logic                wr_finish,
    // processor / memory
    output logic                addr_ok,
    output logic                data_ok,
    output logic                rd_req,
    output logic                wr_req,
    output dcache_pkg::addr_t   rd_addr,
    output dcache_pkg::addr_t   wr_addr,
    // way control
    output dcache_pkg::index_t  rd_index,
    output logic                we0,
    output logic                we1,
    output dcache_pkg::index_t  wr_index,
    output dcache_pkg::tag_t    wr_tag,
    output logic                set_dirty,
    // datapath control
    output logic                way_sel,
    output logic                fill,
    output logic                capture,
    output logic                req_store,
    output dcache_pkg::offset_t req_offset,
    output dcache_pkg::strb_t   req_wstrb,
    output dcache_pkg::word_t   req_wdata
);
    import dcache_pkg::*;

    dc_state_e           state;
    dc_state_e           state_nxt;
    tag_t                req_tag;
    index_t              req_index;
    logic [`DC_SETS-1:0] lru;           // names the victim way per set
    logic                take;
    logic                any_hit;
    logic                victim;
    logic                refill_done;

    assign take        = valid && addr_ok;
    assign any_hit     = (state == LOOKUP) && (hit0 || hit1);
    assign victim      = lru[req_index];   // stable through the whole miss
    assign refill_done = (state == REFILL) && rd_finish;

    //////////////////////////////
    // request buffer

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            req_store <= 1'b0;
            req_tag   <= '0;
            req_index <= '0;
        end else if (take) begin
            req_store <= op;
            req_tag   <= tag;
            req_index <= index;
        end
    end

    always_ff @(posedge clk_g) begin
        if (take) begin
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    //////////////////////////////
    // main fsm

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            data_ok <= 1'b0;
        end else begin
            state   <= state_nxt;
            data_ok <= capture;     // one cycle after lookup hit or rd_finish
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:    if (take) state_nxt = LOOKUP;
            LOOKUP:  state_nxt = any_hit ? IDLE : MISS;
            MISS:    state_nxt = (victim ? dirty1 : dirty0) ? REPLACE : REFILL;
            REPLACE: if (wr_finish) state_nxt = REFILL;
            REFILL:  if (rd_finish) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // lru update on a hit or on the refill write
    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            lru <= '0;
        end else if (any_hit) begin
            lru[req_index] <= hit0;         // point at the way that missed
        end else if (refill_done) begin
            lru[req_index] <= ~victim;      // away from the filled way
        end
    end

    //////////////////////////////
    // outputs

    assign addr_ok  = (state == IDLE);
    assign rd_index = (state == IDLE && valid) ? index : req_index;  // ram sees index a cycle early
    assign we0      = (any_hit && hit0 && req_store) || (refill_done && !victim);
    assign we1      = (any_hit && hit1 && req_store) || (refill_done && victim);
    assign wr_index = req_index;
    assign wr_tag   = req_tag;
    assign set_dirty = req_store;
    assign way_sel  = (state == LOOKUP) ? hit1 : victim;
    assign fill     = (state == REFILL);
    assign capture  = any_hit || refill_done;

    // bus side, level requests dropped in the finish cycle
    assign rd_req  = (state == REFILL) && !rd_finish;
    assign wr_req  = (state == REPLACE) && !wr_finish;
    assign rd_addr = '{tag: req_tag, index: req_index, offset: '0};
    assign wr_addr = '{tag: (victim ? tag1 : tag0), index: req_index, offset: '0};

    a_one_hit: assert property (@(posedge clk_g) disable iff (!arst_n) !(hit0 && hit1))
        else $error("dcache_ctrl: both ways hit");
    a_one_req: assert property (@(posedge clk_g) disable iff (!arst_n) !(rd_req && wr_req))
        else $error("dcache_ctrl: rd_req and wr_req together");
    a_data_ok_pulse: assert property (@(posedge clk_g) disable iff (!arst_n)
        data_ok |=> !data_ok)
        else $error("dcache_ctrl: data_ok longer than one cycle");

endmodule

// ==== dcache/dcache_datapath.sv ====
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_datapath (
    input  logic                clk_g,
    input  logic                arst_n,
    // lines out of the two ways
    input  dcache_pkg::line_t   line0,
    input  dcache_pkg::line_t   line1,
    // controls from the fsm
    input  logic                way_sel,     // 1 picks way1
    input  logic                fill,        // base is the refill line
    input  logic                capture,     // load rdata register
    input  logic                req_store,
    input  dcache_pkg::offset_t req_offset,
    input  dcache_pkg::strb_t   req_wstrb,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::line_t   refill_line,
    // results
    output dcache_pkg::line_t   wr_line,
    output dcache_pkg::line_t   victim_line,
    output dcache_pkg::word_t   rdata
);
    import dcache_pkg::*;

    localparam int BYTES = $bits(strb_t);

    logic [$clog2(`DC_WORDS)-1:0] word_idx;
    line_t                        base_line;
    word_t                        merged_word;

    assign word_idx    = req_offset[4:2];
    assign victim_line = way_sel ? line1 : line0;   // old contents, goes out as wr_data

    //////////////////////////////
    // base line and store merge

    always_comb begin
        base_line   = fill ? refill_line : victim_line;
        merged_word = base_line[word_idx];
        for (int b = 0; b < BYTES; b++) begin
            if (req_store && req_wstrb[b]) begin
                merged_word[8*b +: 8] = req_wdata[8*b +: 8];  // strobed byte only
            end
        end
        wr_line           = base_line;
        wr_line[word_idx] = merged_word;   // unchanged for a load
    end

    //////////////////////////////
    // read data, held for the data_ok cycle

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (capture) begin
            rdata <= wr_line[word_idx];    // store returns the merged word
        end
    end

endmodule

// ==== dcache/dcache_way.sv ====
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_way (
    input  logic                clk_g,
    input  logic                arst_n,
    // read side
    input  dcache_pkg::index_t  rd_index,
    input  dcache_pkg::tag_t    lookup_tag,
    // write side
    input  logic                we,
    input  dcache_pkg::index_t  wr_index,
    input  dcache_pkg::tag_t    wr_tag,
    input  dcache_pkg::line_t   wr_line,
    input  logic                set_dirty,
    // status of the set read last cycle
    output logic                hit,
    output dcache_pkg::line_t   line,
    output dcache_pkg::tag_t    tag,
    output logic                victim_dirty
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0] valid_bits;
    logic [`DC_SETS-1:0] dirty_bits;
    index_t              idx_q;       // index seen by the rams last edge
    logic                set_valid;

    //////////////////////////////
    // storage

    sync_ram #(.payload_t(tag_t)) i_tag_ram (
        .clk_g (clk_g),
        .we    (we),
        .waddr (wr_index),
        .wdata (wr_tag),
        .raddr (rd_index),
        .rdata (tag)
    );

    sync_ram #(.payload_t(line_t)) i_line_ram (
        .clk_g (clk_g),
        .we    (we),            // whole line every time
        .waddr (wr_index),
        .wdata (wr_line),
        .raddr (rd_index),
        .rdata (line)
    );

    // valid and dirty flags, one pair per set
    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            idx_q      <= '0;
        end else begin
            idx_q <= rd_index;      // track ram latency
            if (we) begin
                valid_bits[wr_index] <= 1'b1;
                dirty_bits[wr_index] <= set_dirty;  // refill by a load comes in clean
            end
        end
    end

    //////////////////////////////
    // hit compare

    assign set_valid    = valid_bits[idx_q];
    assign hit          = set_valid && (tag == lookup_tag);
    assign victim_dirty = set_valid && dirty_bits[idx_q];  // needs writeback if evicted

    // the tag that hits was read out of a set already filled at that edge
    a_hit_valid: assert property (@(posedge clk_g) disable iff (!arst_n)
        hit |-> $past(valid_bits[rd_index]))
        else $error("dcache_way: hit on a set that was never filled");

endmodule

// ==== source/sync_ram.sv ====
`timescale 1ns/10ps
`include "dcache_settings.svh"

// one read port, one write port, one cycle read latency
module sync_ram #(
    parameter type payload_t = dcache_pkg::line_t
) (
    input  logic               clk_g,
    input  logic               we,
    input  dcache_pkg::index_t waddr,
    input  payload_t           wdata,
    input  dcache_pkg::index_t raddr,
    output payload_t           rdata
);

    payload_t mem [`DC_SETS];   // one entry per set

    always_ff @(posedge clk_g) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];    // old data on a same-address write
    end

    //////////////////////////////
    // the read port runs every cycle, so the index must be driven once out of reset
    a_raddr_known: assert property (@(posedge clk_g) !$isunknown(raddr))
        else $error("sync_ram: read with unknown address");

endmodule

// ==== common/dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]     tag_t;
    typedef logic [`DC_INDEX_W-1:0]   index_t;
    typedef logic [`DC_OFFSET_W-1:0]  offset_t;  // bits 4:2 pick the word
    typedef logic [`DC_WORD_W-1:0]    word_t;
    typedef logic [`DC_WORD_W/8-1:0]  strb_t;    // one bit per byte

    // word 0 sits in the low bits
    typedef word_t [`DC_WORDS-1:0]    line_t;

    // bus address, msb first
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_t;

    // main fsm, one-hot
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } dc_state_e;

endpackage

// ==== common/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address split, tag | index | offset
`define DC_TAG_W     20
`define DC_INDEX_W   7
`define DC_OFFSET_W  5    // byte offset inside a line

// data geometry
`define DC_WORD_W    32
`define DC_WORDS     8    // words per line

// 2**DC_INDEX_W sets, per way
`define DC_SETS      128

`endif
